// File: compile.f
net_edge_pkg.sv
net_stream_if.sv
route_config.sv
vlan_tagger.sv
vlan_checker.sv
stream_slice_array.sv
net_edge_top.sv
tb_clock_gen.sv
net_edge_chk.sv
net_edge_tb.sv

// File: net_edge_chk.sv
// Checks only the wire TX and user RX outputs of net_edge_top; needs assertions enabled in the tool
`timescale 1ns/1ps

module net_edge_chk (
    input logic                                   aclk,
    input logic                                   aresetn,
    input logic [net_edge_pkg::NET_DATA_BITS-1:0] net_tx_data,
    input logic [net_edge_pkg::NET_KEEP_BITS-1:0] net_tx_keep,
    input logic                                   net_tx_last,
    input logic                                   net_tx_valid,
    input logic                                   net_tx_ready,
    input logic [net_edge_pkg::NET_DATA_BITS-1:0] rx_data,
    input logic [net_edge_pkg::NET_KEEP_BITS-1:0] rx_keep,
    input logic                                   rx_last,
    input net_edge_pkg::route_id_t                rx_tdest,
    input logic                                   rx_valid,
    input logic                                   rx_ready
);

    // Stalled beat stays offered and unchanged
    tx_stall_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        net_tx_valid && !net_tx_ready |=> net_tx_valid && $stable(net_tx_data)
            && $stable(net_tx_keep) && $stable(net_tx_last))
        else $error("net_tx beat dropped or changed while stalled");

    rx_stall_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        rx_valid && !rx_ready |=> rx_valid && $stable(rx_data) && $stable(rx_keep)
            && $stable(rx_last) && $stable(rx_tdest))
        else $error("rx beat dropped or changed while stalled");

    reset_quiet: assert property (@(posedge aclk) !aresetn |=> !net_tx_valid && !rx_valid)
        else $error("valid output high after a reset edge");

endmodule

bind net_edge_top net_edge_chk u_chk (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .net_tx_data  (net_tx_data),
    .net_tx_keep  (net_tx_keep),
    .net_tx_last  (net_tx_last),
    .net_tx_valid (net_tx_valid),
    .net_tx_ready (net_tx_ready),
    .rx_data      (rx_data),
    .rx_keep      (rx_keep),
    .rx_last      (rx_last),
    .rx_tdest     (rx_tdest),
    .rx_valid     (rx_valid),
    .rx_ready     (rx_ready)
);

// File: net_edge_pkg.sv
// Widths assume a 64-bit single-clock stream; route ids are 14 bits with the tag in the low bits
package net_edge_pkg;

    // Stream widths
    localparam int NET_DATA_BITS = 64;
    localparam int NET_KEEP_BITS = NET_DATA_BITS / 8;

    // Route id and route-control word
    localparam int ROUTE_ID_BITS = 14;

    // Tag fields inside a route id
    localparam int SENDER_HI = 9;
    localparam int SENDER_LO = 6;
    localparam int RECV_HI   = 5;
    localparam int RECV_LO   = 2;
    localparam int FLAGS_HI  = 1;
    localparam int FLAGS_LO  = 0;

    // Fields of the route-control word
    localparam int LOCAL_ID_HI   = 5;
    localparam int LOCAL_ID_LO   = 2;
    localparam int FILTER_EN_BIT = 0;

    // Register slices on each path toward the wire
    localparam int N_REG_NET_S0 = 2;

    typedef logic [ROUTE_ID_BITS-1:0] route_id_t;

    // One TX or wire beat, 73 bits
    typedef struct packed {
        logic [NET_DATA_BITS-1:0] data;
        logic [NET_KEEP_BITS-1:0] keep;
        logic                     last;
    } net_beat_t;

    // One RX beat toward the user, 87 bits
    typedef struct packed {
        net_beat_t frame;
        route_id_t tdest;
    } net_rx_beat_t;

endpackage

// File: net_edge_tb.sv
// net_tx is looped back to net_rx; each row is drained before the next, so routes never change mid-frame
`timescale 1ns/1ps

module net_edge_tb;

    import net_edge_pkg::*;

    localparam int N_ROWS          = 12;
    localparam int MAX_LEN         = 6;
    localparam int WATCHDOG_CYCLES = N_ROWS * MAX_LEN * 20;

    typedef struct packed {
        logic       rdma_stb;
        route_id_t  rdma_id;
        logic       tcp_stb;
        route_id_t  tcp_id;
        route_id_t  dflt_id;
        route_id_t  ctrl;
        logic [2:0] len;
        route_id_t  exp_route;
        logic       exp_pass;
        logic       rand_ready;
    } row_t;

    logic                     aclk, aresetn;
    logic [NET_DATA_BITS-1:0] tx_data, net_tx_data, rx_data;
    logic [NET_KEEP_BITS-1:0] tx_keep, net_tx_keep, rx_keep;
    logic                     tx_last, tx_valid, tx_ready;
    logic                     net_tx_last, net_tx_valid, net_rx_ready;
    logic                     rx_last, rx_valid, rx_ready;
    logic                     rdma_route_valid, tcp_route_valid;
    route_id_t                rx_tdest, rdma_route_id, tcp_route_id, default_route_id, vlan_ctrl;

    row_t         rows [N_ROWS];
    net_rx_beat_t exp_q [$];
    route_id_t    exp_tag;
    logic [15:0]  lfsr_state;
    logic         rand_mode;
    logic         wire_in_hdr;
    int           wire_beats, target;
    int           tag_errors, data_errors, other_errors;

    tb_clock_gen u_clk (.aclk(aclk), .aresetn(aresetn));

    // Wire side looped straight back into the RX path
    net_edge_top u_dut (
        .aclk(aclk), .aresetn(aresetn),
        .tx_data(tx_data), .tx_keep(tx_keep), .tx_last(tx_last),
        .tx_valid(tx_valid), .tx_ready(tx_ready),
        .net_tx_data(net_tx_data), .net_tx_keep(net_tx_keep), .net_tx_last(net_tx_last),
        .net_tx_valid(net_tx_valid), .net_tx_ready(net_rx_ready),
        .net_rx_data(net_tx_data), .net_rx_keep(net_tx_keep), .net_rx_last(net_tx_last),
        .net_rx_valid(net_tx_valid), .net_rx_ready(net_rx_ready),
        .rx_data(rx_data), .rx_keep(rx_keep), .rx_last(rx_last), .rx_tdest(rx_tdest),
        .rx_valid(rx_valid), .rx_ready(rx_ready),
        .rdma_route_id(rdma_route_id), .rdma_route_valid(rdma_route_valid),
        .tcp_route_id(tcp_route_id), .tcp_route_valid(tcp_route_valid),
        .default_route_id(default_route_id), .vlan_ctrl(vlan_ctrl)
    );

    // Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        lfsr_step = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic load_frame_table();
        // rdma stb/id, tcp stb/id, default, vlan_ctrl, len, tag route, pass, random rx_ready
        rows[0]  = '{1'b0, 14'h0000, 1'b0, 14'h0000, 14'h00A5, 14'h0000, 3'd3, 14'h00A5, 1'b1, 1'b0};
        rows[1]  = '{1'b1, 14'h1234, 1'b0, 14'h0000, 14'h00A5, 14'h0000, 3'd1, 14'h1234, 1'b1, 1'b0};
        rows[2]  = '{1'b0, 14'h0000, 1'b1, 14'h0348, 14'h00A5, 14'h0000, 3'd4, 14'h1234, 1'b1, 1'b0};
        rows[3]  = '{1'b1, 14'h0000, 1'b0, 14'h0000, 14'h00A5, 14'h0000, 3'd2, 14'h0348, 1'b1, 1'b0};
        rows[4]  = '{1'b0, 14'h0000, 1'b1, 14'h0000, 14'h2F3C, 14'h0000, 3'd6, 14'h2F3C, 1'b1, 1'b1};
        rows[5]  = '{1'b0, 14'h0000, 1'b0, 14'h0000, 14'h2F3C, 14'h003D, 3'd5, 14'h2F3C, 1'b1, 1'b1};
        rows[6]  = '{1'b0, 14'h0000, 1'b0, 14'h0000, 14'h2F3C, 14'h0009, 3'd3, 14'h2F3C, 1'b0, 1'b0};
        rows[7]  = '{1'b1, 14'h0348, 1'b0, 14'h0000, 14'h2F3C, 14'h0009, 3'd2, 14'h0348, 1'b1, 1'b1};
        rows[8]  = '{1'b1, 14'h1234, 1'b0, 14'h0000, 14'h2F3C, 14'h0009, 3'd6, 14'h1234, 1'b0, 1'b1};
        rows[9]  = '{1'b0, 14'h0000, 1'b0, 14'h0000, 14'h2F3C, 14'h0035, 3'd6, 14'h1234, 1'b1, 1'b1};
        rows[10] = '{1'b1, 14'h0000, 1'b0, 14'h0000, 14'h0155, 14'h0008, 3'd1, 14'h0155, 1'b1, 1'b1};
        rows[11] = '{1'b0, 14'h0000, 1'b1, 14'h0B08, 14'h0155, 14'h0009, 3'd4, 14'h0B08, 1'b1, 1'b1};
    endtask

    // Strobes last one cycle, the rest stays until the next row
    task automatic apply_route(input row_t r);
        @(negedge aclk);
        rdma_route_valid = r.rdma_stb;
        rdma_route_id    = r.rdma_id;
        tcp_route_valid  = r.tcp_stb;
        tcp_route_id     = r.tcp_id;
        default_route_id = r.dflt_id;
        vlan_ctrl        = r.ctrl;
        rand_mode       <= r.rand_ready;
        exp_tag          = r.exp_route;
        @(negedge aclk);
        rdma_route_valid = 1'b0;
        tcp_route_valid  = 1'b0;
    endtask

    task automatic send_frame(input int row, input int len, input route_id_t route, input logic pass);
        net_rx_beat_t beat;
        for (int b = 0; b < len; b++) begin
            beat.frame.data = {16'hC0DE, 16'(row), 16'(b), 16'h5A5A};
            beat.frame.keep = (b == len - 1) ? ({NET_KEEP_BITS{1'b1}} >> (row % NET_KEEP_BITS))
                                             : {NET_KEEP_BITS{1'b1}};
            beat.frame.last = (b == len - 1);
            beat.tdest      = route;
            if (pass) begin
                exp_q.push_back(beat);
            end
            tx_data  = beat.frame.data;
            tx_keep  = beat.frame.keep;
            tx_last  = beat.frame.last;
            tx_valid = 1'b1;
            @(posedge aclk);
            while (!tx_ready) @(posedge aclk);
            @(negedge aclk);
        end
        tx_valid = 1'b0;
    endtask

    task automatic wait_drain(input int wire_target);
        while (wire_beats != wire_target || exp_q.size() != 0) @(negedge aclk);
    endtask

    always @(negedge aclk) begin
        if (rand_mode) begin
            lfsr_state = lfsr_step(lfsr_state);
            rx_ready   = lfsr_state[0];
        end else begin
            rx_ready = 1'b1;
        end
    end

    // Wire monitor, checks the tag beat of every frame
    always @(posedge aclk) begin
        if (!aresetn) begin
            wire_in_hdr <= 1'b1;
            wire_beats  <= 0;
        end else if (net_tx_valid && net_rx_ready) begin
            wire_beats <= wire_beats + 1;
            if (wire_in_hdr) begin
                assert (net_tx_data == NET_DATA_BITS'(exp_tag) && net_tx_keep == '1 && !net_tx_last)
                else begin
                    tag_errors++;
                    $display("** Error at %0t: tag beat %h, expected route %h", $time,
                             net_tx_data, exp_tag);
                end
                wire_in_hdr <= 1'b0;
            end else if (net_tx_last) begin
                wire_in_hdr <= 1'b1;
            end
        end
    end

    always @(posedge aclk) begin : rx_monitor
        net_rx_beat_t exp_beat;
        if (aresetn && rx_valid && rx_ready) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("Beat arrived on rx at %0t with no frame expected, data %h", $time, rx_data);
            end else begin
                exp_beat = exp_q.pop_front();
                assert (rx_data == exp_beat.frame.data && rx_keep == exp_beat.frame.keep
                        && rx_last == exp_beat.frame.last && rx_tdest == exp_beat.tdest)
                else begin
                    data_errors++;
                    $display("** Error at %0t: rx %h/%h/%b/%h, expected %h/%h/%b/%h", $time,
                             rx_data, rx_keep, rx_last, rx_tdest, exp_beat.frame.data,
                             exp_beat.frame.keep, exp_beat.frame.last, exp_beat.tdest);
                end
            end
        end
    end

    initial begin
        @(posedge aclk);
        while (!aresetn) begin
            @(negedge aclk);
            if (!aresetn) begin
                assert (!net_tx_valid && !rx_valid)
                else begin
                    other_errors++;
                    $display("** Error at %0t: valid output high during reset", $time);
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("Run stopped after %0d cycles without finishing all rows", WATCHDOG_CYCLES);
        $display("Errors: tag %0d, rx %0d, other %0d", tag_errors, data_errors, other_errors);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        tx_data = '0;
        tx_keep = '0;
        tx_last = 1'b0;
        tx_valid = 1'b0;
        rx_ready = 1'b1;
        rdma_route_valid = 1'b0;
        rdma_route_id = '0;
        tcp_route_valid = 1'b0;
        tcp_route_id = '0;
        default_route_id = '0;
        vlan_ctrl = '0;
        rand_mode <= 1'b0;
        lfsr_state = 16'd50;
        exp_tag = '0;
        tag_errors = 0;
        data_errors = 0;
        other_errors = 0;
        load_frame_table();
        while (aresetn !== 1'b1) @(negedge aclk);
        for (int i = 0; i < N_ROWS; i++) begin
            // Tag beat plus body beats cross the wire, dropped or not
            target = wire_beats + int'(rows[i].len) + 1;
            apply_route(rows[i]);
            send_frame(i, int'(rows[i].len), rows[i].exp_route, rows[i].exp_pass);
            wait_drain(target);
        end
        $display("Errors: tag %0d, rx %0d, other %0d", tag_errors, data_errors, other_errors);
        if (tag_errors + data_errors + other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: net_edge_top.sv
// Single clock aclk; every frame on the wire starts with one tag beat holding the route id
`timescale 1ns/1ps

module net_edge_top (
    input  logic                                   aclk,
    input  logic                                   aresetn,
    input  logic [net_edge_pkg::NET_DATA_BITS-1:0] tx_data,
    input  logic [net_edge_pkg::NET_KEEP_BITS-1:0] tx_keep,
    input  logic                                   tx_last,
    input  logic                                   tx_valid,
    output logic                                   tx_ready,
    output logic [net_edge_pkg::NET_DATA_BITS-1:0] net_tx_data,
    output logic [net_edge_pkg::NET_KEEP_BITS-1:0] net_tx_keep,
    output logic                                   net_tx_last,
    output logic                                   net_tx_valid,
    input  logic                                   net_tx_ready,
    input  logic [net_edge_pkg::NET_DATA_BITS-1:0] net_rx_data,
    input  logic [net_edge_pkg::NET_KEEP_BITS-1:0] net_rx_keep,
    input  logic                                   net_rx_last,
    input  logic                                   net_rx_valid,
    output logic                                   net_rx_ready,
    output logic [net_edge_pkg::NET_DATA_BITS-1:0] rx_data,
    output logic [net_edge_pkg::NET_KEEP_BITS-1:0] rx_keep,
    output logic                                   rx_last,
    output net_edge_pkg::route_id_t                rx_tdest,
    output logic                                   rx_valid,
    input  logic                                   rx_ready,
    input  net_edge_pkg::route_id_t                rdma_route_id,
    input  logic                                   rdma_route_valid,
    input  net_edge_pkg::route_id_t                tcp_route_id,
    input  logic                                   tcp_route_valid,
    input  net_edge_pkg::route_id_t                default_route_id,
    input  net_edge_pkg::route_id_t                vlan_ctrl
);

    import net_edge_pkg::*;

    route_id_t  tx_route_id;
    logic       filter_en;
    logic [3:0] local_id;

    net_stream_if #(.beat_t(net_beat_t))    user_tx_s ();
    net_stream_if #(.beat_t(net_beat_t))    tagged_tx_s ();
    net_stream_if #(.beat_t(net_beat_t))    wire_tx_s ();
    net_stream_if #(.beat_t(net_beat_t))    wire_rx_s ();
    net_stream_if #(.beat_t(net_rx_beat_t)) checked_rx_s ();
    net_stream_if #(.beat_t(net_rx_beat_t)) user_rx_s ();

    // User TX side
    assign user_tx_s.beat.data = tx_data;
    assign user_tx_s.beat.keep = tx_keep;
    assign user_tx_s.beat.last = tx_last;
    assign user_tx_s.valid     = tx_valid;
    assign tx_ready            = user_tx_s.ready;

    // Wire TX side
    assign net_tx_data     = wire_tx_s.beat.data;
    assign net_tx_keep     = wire_tx_s.beat.keep;
    assign net_tx_last     = wire_tx_s.beat.last;
    assign net_tx_valid    = wire_tx_s.valid;
    assign wire_tx_s.ready = net_tx_ready;

    // Wire RX side
    assign wire_rx_s.beat.data = net_rx_data;
    assign wire_rx_s.beat.keep = net_rx_keep;
    assign wire_rx_s.beat.last = net_rx_last;
    assign wire_rx_s.valid     = net_rx_valid;
    assign net_rx_ready        = wire_rx_s.ready;

    // User RX side
    assign rx_data         = user_rx_s.beat.frame.data;
    assign rx_keep         = user_rx_s.beat.frame.keep;
    assign rx_last         = user_rx_s.beat.frame.last;
    assign rx_tdest        = user_rx_s.beat.tdest;
    assign rx_valid        = user_rx_s.valid;
    assign user_rx_s.ready = rx_ready;

    route_config u_route_config (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .rdma_route_id    (rdma_route_id),
        .rdma_route_valid (rdma_route_valid),
        .tcp_route_id     (tcp_route_id),
        .tcp_route_valid  (tcp_route_valid),
        .default_route_id (default_route_id),
        .vlan_ctrl        (vlan_ctrl),
        .tx_route_id      (tx_route_id),
        .filter_en        (filter_en),
        .local_id         (local_id)
    );

    vlan_tagger u_vlan_tagger (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .tx_route_id (tx_route_id),
        .user_tx     (user_tx_s),
        .tagged_tx   (tagged_tx_s)
    );

    stream_slice_array #(
        .N_STAGES (N_REG_NET_S0),
        .beat_t   (net_beat_t)
    ) u_tx_slices (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .in_stream  (tagged_tx_s),
        .out_stream (wire_tx_s)
    );

    vlan_checker u_vlan_checker (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .filter_en (filter_en),
        .local_id  (local_id),
        .wire_rx   (wire_rx_s),
        .user_rx   (checked_rx_s)
    );

    stream_slice_array #(
        .N_STAGES (N_REG_NET_S0),
        .beat_t   (net_rx_beat_t)
    ) u_rx_slices (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .in_stream  (checked_rx_s),
        .out_stream (user_rx_s)
    );

endmodule

// File: net_stream_if.sv
// Valid/ready stream; a beat moves on an aclk edge with both high and holds while stalled
`timescale 1ns/1ps

interface net_stream_if #(
    parameter type beat_t = net_edge_pkg::net_beat_t
);

    beat_t beat;
    logic  valid;
    logic  ready;

    modport source (
        output beat,
        output valid,
        input  ready
    );

    modport sink (
        input  beat,
        input  valid,
        output ready
    );

endinterface

// File: route_config.sv
// Route ids are held until the next strobe; an id of zero means the source has no route
`timescale 1ns/1ps

module route_config (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  net_edge_pkg::route_id_t rdma_route_id,
    input  logic                  rdma_route_valid,
    input  net_edge_pkg::route_id_t tcp_route_id,
    input  logic                  tcp_route_valid,
    input  net_edge_pkg::route_id_t default_route_id,
    input  net_edge_pkg::route_id_t vlan_ctrl,
    output net_edge_pkg::route_id_t tx_route_id,
    output logic                  filter_en,
    output logic [3:0]            local_id
);

    import net_edge_pkg::*;

    route_id_t rdma_held;
    route_id_t tcp_held;
    route_id_t ctrl_q;

    // Last id seen on each strobe
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rdma_held <= '0;
            tcp_held  <= '0;
        end else begin
            if (rdma_route_valid) begin
                rdma_held <= rdma_route_id;
            end
            if (tcp_route_valid) begin
                tcp_held <= tcp_route_id;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q <= vlan_ctrl;
        end
    end

    // RDMA first, then TCP, else the external default
    assign tx_route_id = (rdma_held != '0) ? rdma_held :
                         (tcp_held != '0)  ? tcp_held  :
                         default_route_id;

    assign filter_en = ctrl_q[FILTER_EN_BIT];
    assign local_id  = ctrl_q[LOCAL_ID_HI:LOCAL_ID_LO];

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds net_edge_tb with Verilator and runs it; exits non-zero unless the run passes

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module net_edge_tb -Mdir obj_dir -f compile.f; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vnet_edge_tb)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation process exited with status $status"
    exit 1
fi

if grep -qx "Simulation PASSED" <<< "$output"; then
    exit 0
fi
exit 1

// File: stream_slice_array.sv
// Each stage adds one cycle of latency and holds up to two beats; ready is registered
`timescale 1ns/1ps

module stream_slice_array #(
    parameter int  N_STAGES = 2,
    parameter type beat_t   = logic
) (
    input  logic         aclk,
    input  logic         aresetn,
    net_stream_if.sink   in_stream,
    net_stream_if.source out_stream
);

    beat_t stg_beat  [N_STAGES+1];
    logic  stg_valid [N_STAGES+1];
    logic  stg_ready [N_STAGES+1];

    assign stg_beat[0]  = in_stream.beat;
    assign stg_valid[0] = in_stream.valid;
    assign in_stream.ready = stg_ready[0];

    assign out_stream.beat  = stg_beat[N_STAGES];
    assign out_stream.valid = stg_valid[N_STAGES];
    assign stg_ready[N_STAGES] = out_stream.ready;

    for (genvar i = 0; i < N_STAGES; i++) begin : g_stage
        beat_t main_beat;
        beat_t skid_beat;
        logic  main_valid;
        logic  skid_valid;
        logic  main_load;

        // Main register is free when empty or its beat is leaving
        assign main_load = ~main_valid | stg_ready[i+1];

        always_ff @(posedge aclk) begin
            if (!aresetn) begin
                main_valid <= 1'b0;
                skid_valid <= 1'b0;
            end else if (main_load) begin
                main_valid <= skid_valid | stg_valid[i];
                skid_valid <= 1'b0;
            end else if (stg_valid[i] && !skid_valid) begin
                skid_valid <= 1'b1;
            end
        end

        // Skid drains first so order is kept
        always_ff @(posedge aclk) begin
            if (main_load) begin
                main_beat <= skid_valid ? skid_beat : stg_beat[i];
            end
            if (!main_load && !skid_valid) begin
                skid_beat <= stg_beat[i];
            end
        end

        assign stg_ready[i]   = ~skid_valid;
        assign stg_valid[i+1] = main_valid;
        assign stg_beat[i+1]  = main_beat;
    end

endmodule

// File: tb_clock_gen.sv
// Free-running aclk of period 100 ns; aresetn held low for the first RESET_CYCLES rising edges
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 50,
    parameter int RESET_CYCLES   = 10
) (
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk = 1'b0;
        forever #(HALF_PERIOD_NS) aclk = ~aclk;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
    end

endmodule

// File: vlan_checker.sv
// Expects a tag beat at the start of every frame; dropped frames are consumed at full rate
`timescale 1ns/1ps

module vlan_checker (
    input  logic         aclk,
    input  logic         aresetn,
    input  logic         filter_en,
    input  logic [3:0]   local_id,
    net_stream_if.sink   wire_rx,
    net_stream_if.source user_rx
);

    import net_edge_pkg::*;

    logic         in_header;
    logic         frame_pass;
    logic         tag_match;
    logic         wire_xfer;
    route_id_t    frame_route;
    route_id_t    tag_route;
    net_rx_beat_t out_beat;

    assign tag_route = wire_rx.beat.data[ROUTE_ID_BITS-1:0];

    // Receiver field must match when filtering is on
    assign tag_match = ~filter_en | (tag_route[RECV_HI:RECV_LO] == local_id);

    // Tag beat and dropped beats are always taken
    assign wire_rx.ready = in_header | ~frame_pass | user_rx.ready;
    assign wire_xfer     = wire_rx.valid & wire_rx.ready;

    assign out_beat.frame = wire_rx.beat;
    assign out_beat.tdest = frame_route;

    assign user_rx.valid = ~in_header & frame_pass & wire_rx.valid;
    assign user_rx.beat  = out_beat;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            in_header  <= 1'b1;
            frame_pass <= 1'b0;
        end else if (wire_xfer) begin
            if (in_header) begin
                frame_pass <= tag_match;
                // A tag beat with last set is a frame with no body
                in_header  <= wire_rx.beat.last;
            end else if (wire_rx.beat.last) begin
                in_header <= 1'b1;
            end
        end
    end

    // Route id of the frame in flight
    always_ff @(posedge aclk) begin
        if (in_header && wire_xfer) begin
            frame_route <= tag_route;
        end
    end

endmodule

// File: vlan_tagger.sv
// One tag beat precedes every frame; user ready is low while the tag beat is offered
`timescale 1ns/1ps

module vlan_tagger (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  net_edge_pkg::route_id_t tx_route_id,
    net_stream_if.sink              user_tx,
    net_stream_if.source            tagged_tx
);

    import net_edge_pkg::*;

    logic      in_header;
    logic      tagged_xfer;
    net_beat_t tag_beat;

    // Route id in the low bits, rest of the word zero
    assign tag_beat.data = NET_DATA_BITS'(tx_route_id);
    assign tag_beat.keep = '1;
    assign tag_beat.last = 1'b0;

    // Tag is offered as soon as the first user beat shows up
    assign tagged_tx.valid = user_tx.valid;
    assign tagged_tx.beat  = in_header ? tag_beat : user_tx.beat;

    // User beat waits until the tag has gone
    assign user_tx.ready = ~in_header & tagged_tx.ready;

    assign tagged_xfer = tagged_tx.valid & tagged_tx.ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            in_header <= 1'b1;
        end else if (tagged_xfer) begin
            if (in_header) begin
                in_header <= 1'b0;
            end else if (user_tx.beat.last) begin
                in_header <= 1'b1;
            end
        end
    end

endmodule
